// ==== design/cpu8_macros.svh ====
/*
 * widths, register count and opcode values for the 8-bit processor
 */

`ifndef CPU8_MACROS_SVH
`define CPU8_MACROS_SVH

// datapath and register file sizes
`define CPU8_DATA_W     8
`define CPU8_ADDR_W     32
`define CPU8_INSTR_W    32
`define CPU8_REG_CNT    8
`define CPU8_REG_IDX_W  3

// opcode values, instruction bits 31..24
`define CPU8_OP_LOADI   8'd0
`define CPU8_OP_MOV     8'd1
`define CPU8_OP_ADD     8'd2
`define CPU8_OP_SUB     8'd3
`define CPU8_OP_AND     8'd4
`define CPU8_OP_OR      8'd5
`define CPU8_OP_J       8'd6
`define CPU8_OP_BEQ     8'd7
`define CPU8_OP_BNE     8'd8
// shift amount comes from the immediate
`define CPU8_OP_SRL     8'd9
`define CPU8_OP_SLL     8'd10

`endif

// ==== design/cpu8_pkg.sv ====
/*
 * shared types of the 8-bit processor
 * data, address, instruction and register index types, ALU and branch enums
 */

`default_nettype none

`include "cpu8_macros.svh"

package cpu8_pkg;

    // register or ALU value
    typedef logic [`CPU8_DATA_W-1:0]    data_t;
    // byte address, pc width
    typedef logic [`CPU8_ADDR_W-1:0]    addr_t;
    // raw instruction word
    typedef logic [`CPU8_INSTR_W-1:0]   instr_t;
    // register number
    typedef logic [`CPU8_REG_IDX_W-1:0] reg_idx_t;
    // opcode field, top byte of the word
    typedef logic [7:0]                 opcode_t;

    // ALU operations
    // sub and sll are built around these outside the ALU
    typedef enum logic [2:0] {
        ALU_FWD = 3'd0,
        ALU_ADD = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SRL = 3'd4
    } alu_op_e;

    // branch condition on the ALU zero flag
    typedef enum logic [1:0] {
        BR_NONE  = 2'd0,
        BR_ZERO  = 2'd1,
        BR_NZERO = 2'd2
    } branch_e;

endpackage

`default_nettype wire

// ==== design/pc_unit.sv ====
/*
 * program counter with pc+4 adder, branch target adder and next-pc select
 */

`default_nettype none
`timescale 1ns/1ps

`include "cpu8_macros.svh"

module pc_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               jump,
    input  cpu8_pkg::branch_e  branch,
    input  logic               zero,
    input  cpu8_pkg::data_t    offset,
    output cpu8_pkg::addr_t    pc
);

    cpu8_pkg::addr_t pc_plus4;
    cpu8_pkg::addr_t offset_ext;
    cpu8_pkg::addr_t target;
    cpu8_pkg::addr_t pc_next;
    logic            br_taken;

    // sequential address
    assign pc_plus4 = pc + `CPU8_ADDR_W'd4;

    // word offset, sign extended and scaled to bytes
    assign offset_ext = {{(`CPU8_ADDR_W-`CPU8_DATA_W-2){offset[`CPU8_DATA_W-1]}}, offset, 2'b00};
    assign target = pc_plus4 + offset_ext;

    // branch condition from zero flag
    always_comb begin
        case (branch)
            cpu8_pkg::BR_ZERO:  br_taken = zero;
            cpu8_pkg::BR_NZERO: br_taken = !zero;
            default:            br_taken = 1'b0;
        endcase
    end

    // jump or taken branch goes to target
    assign pc_next = (jump || br_taken) ? target : pc_plus4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // instruction fetch relies on word aligned pc
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== design/control_unit.sv ====
/*
 * opcode decoder
 * write enable, operand selects, ALU op, reverse, jump and branch kind
 */

`default_nettype none
`timescale 1ns/1ps

`include "cpu8_macros.svh"

module control_unit (
    input  logic               arst_n,
    input  cpu8_pkg::opcode_t  opcode,
    output logic               reg_we,
    output logic               neg_sel,
    output logic               imm_sel,
    output logic               rev_en,
    output logic               jump,
    output cpu8_pkg::alu_op_e  alu_op,
    output cpu8_pkg::branch_e  branch
);

    always_comb begin
        // defaults, no write and no control flow
        reg_we  = 1'b0;
        neg_sel = 1'b0;
        imm_sel = 1'b0;
        rev_en  = 1'b0;
        jump    = 1'b0;
        alu_op  = cpu8_pkg::ALU_FWD;
        branch  = cpu8_pkg::BR_NONE;

        case (opcode)
            `CPU8_OP_LOADI: begin
                // immediate straight through
                reg_we  = 1'b1;
                imm_sel = 1'b1;
            end
            `CPU8_OP_MOV: begin
                reg_we  = 1'b1;
            end
            `CPU8_OP_ADD: begin
                reg_we  = 1'b1;
                alu_op  = cpu8_pkg::ALU_ADD;
            end
            `CPU8_OP_SUB: begin
                // add the negated second operand
                reg_we  = 1'b1;
                neg_sel = 1'b1;
                alu_op  = cpu8_pkg::ALU_ADD;
            end
            `CPU8_OP_AND: begin
                reg_we  = 1'b1;
                alu_op  = cpu8_pkg::ALU_AND;
            end
            `CPU8_OP_OR: begin
                reg_we  = 1'b1;
                alu_op  = cpu8_pkg::ALU_OR;
            end
            `CPU8_OP_J: begin
                jump    = 1'b1;
            end
            `CPU8_OP_BEQ, `CPU8_OP_BNE: begin
                // compare by subtraction
                neg_sel = 1'b1;
                alu_op  = cpu8_pkg::ALU_ADD;
                branch  = (opcode == `CPU8_OP_BEQ) ? cpu8_pkg::BR_ZERO : cpu8_pkg::BR_NZERO;
            end
            `CPU8_OP_SRL, `CPU8_OP_SLL: begin
                // amount in the immediate
                reg_we  = 1'b1;
                imm_sel = 1'b1;
                alu_op  = cpu8_pkg::ALU_SRL;
                // left shift via reversed right shift
                rev_en  = (opcode == `CPU8_OP_SLL);
            end
            default: begin
                // unknown opcode, plain pc+4
            end
        endcase

        // held in reset, nothing retires
        if (!arst_n) begin
            reg_we = 1'b0;
            jump   = 1'b0;
            branch = cpu8_pkg::BR_NONE;
        end

        // pc_unit expects at most one redirect source
        a_one_redirect : assert (!(jump && branch != cpu8_pkg::BR_NONE))
            else $error("jump and branch both active, opcode %h", opcode);
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
/*
 * eight 8-bit registers
 * two combinational read ports, one synchronous write port
 */

`default_nettype none
`timescale 1ns/1ps

`include "cpu8_macros.svh"

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  cpu8_pkg::reg_idx_t  rs1,
    input  cpu8_pkg::reg_idx_t  rs2,
    input  cpu8_pkg::reg_idx_t  rd,
    input  cpu8_pkg::data_t     wdata,
    input  logic                we,
    output cpu8_pkg::data_t     rd1,
    output cpu8_pkg::data_t     rd2
);

    // register array
    cpu8_pkg::data_t regs [`CPU8_REG_CNT];

    // written at the edge and cleared on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU8_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wdata;
        end
    end

    // reads see the old value until the edge
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // write index must come from a decoded instruction
    a_rd_known : assert property (
        @(posedge clk) disable iff (!arst_n) we |-> !$isunknown(rd)
    ) else $error("register write with unknown index");

endmodule

`default_nettype wire

// ==== design/alu.sv ====
/*
 * 8-bit ALU
 * forward, add, and, or, logical right shift, zero flag
 */

`default_nettype none
`timescale 1ns/1ps

module alu (
    input  cpu8_pkg::data_t    a,
    input  cpu8_pkg::data_t    b,
    input  cpu8_pkg::alu_op_e  op,
    output cpu8_pkg::data_t    result,
    output logic               zero
);

    // shift amount, low three bits of b
    logic [2:0] shamt;

    assign shamt = b[2:0];

    always_comb begin
        case (op)
            cpu8_pkg::ALU_FWD: begin
                // loadi and mov pass b
                result = b;
            end
            cpu8_pkg::ALU_ADD: begin
                // also sub and compare, b already negated
                result = a + b;
            end
            cpu8_pkg::ALU_AND: begin
                result = a & b;
            end
            cpu8_pkg::ALU_OR: begin
                result = a | b;
            end
            cpu8_pkg::ALU_SRL: begin
                // zero fill, sll reuses this with reversed bits
                result = a >> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branch condition
    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== design/cpu.sv ====
/*
 * single-cycle 8-bit processor top level
 * field split, two's complement, operand muxes, bit reverse, write-back trace
 */

`default_nettype none
`timescale 1ns/1ps

module cpu (
    input  logic                clk,
    input  logic                arst_n,
    input  cpu8_pkg::instr_t    instr,
    output cpu8_pkg::addr_t     pc,
    output logic                wb_en,
    output cpu8_pkg::reg_idx_t  wb_reg,
    output cpu8_pkg::data_t     wb_data
);

    // instruction fields
    cpu8_pkg::opcode_t   opcode;
    cpu8_pkg::reg_idx_t  rd;
    cpu8_pkg::reg_idx_t  rs1;
    cpu8_pkg::reg_idx_t  rs2;
    cpu8_pkg::data_t     imm;
    cpu8_pkg::data_t     offset;

    // control
    logic                reg_we;
    logic                neg_sel;
    logic                imm_sel;
    logic                rev_en;
    logic                jump;
    cpu8_pkg::alu_op_e   alu_op;
    cpu8_pkg::branch_e   branch;

    // datapath
    cpu8_pkg::data_t     rd1;
    cpu8_pkg::data_t     rd2;
    cpu8_pkg::data_t     rd2_neg;
    cpu8_pkg::data_t     op_b_reg;
    cpu8_pkg::data_t     op_a;
    cpu8_pkg::data_t     op_b;
    cpu8_pkg::data_t     alu_out;
    cpu8_pkg::data_t     wdata;
    logic                zero;

    // mirror bit order, used on both sides of the ALU
    function automatic cpu8_pkg::data_t bit_rev(input cpu8_pkg::data_t v);
        cpu8_pkg::data_t r;
        for (int i = 0; i < $bits(v); i++) begin
            r[i] = v[$bits(v)-1-i];
        end
        return r;
    endfunction

    assign opcode = instr[31:24];
    assign offset = instr[23:16];
    assign rd     = instr[18:16];
    assign rs1    = instr[10:8];
    assign rs2    = instr[2:0];
    assign imm    = instr[7:0];

    control_unit i_control_unit (
        .arst_n  (arst_n),
        .opcode  (opcode),
        .reg_we  (reg_we),
        .neg_sel (neg_sel),
        .imm_sel (imm_sel),
        .rev_en  (rev_en),
        .jump    (jump),
        .alu_op  (alu_op),
        .branch  (branch)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wdata  (wdata),
        .we     (reg_we),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    // two's complement for sub and compare
    assign rd2_neg  = ~rd2 + 1'b1;
    assign op_b_reg = neg_sel ? rd2_neg : rd2;
    // immediate overrides the register operand
    assign op_b     = imm_sel ? imm : op_b_reg;

    // sll as reversed srl
    assign op_a = rev_en ? bit_rev(rd1) : rd1;

    alu i_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (alu_op),
        .result (alu_out),
        .zero   (zero)
    );

    // undo the reversal on the way back
    assign wdata = rev_en ? bit_rev(alu_out) : alu_out;

    pc_unit i_pc_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .jump   (jump),
        .branch (branch),
        .zero   (zero),
        .offset (offset),
        .pc     (pc)
    );

    // write-back trace, valid before the retiring edge
    assign wb_en   = reg_we;
    assign wb_reg  = rd;
    assign wb_data = wdata;

endmodule

`default_nettype wire

// ==== verif/cpu_tb.sv ====
/*
 * directed testbench for the 8-bit processor, acting as instruction memory
 * reference register model, encoders and per-test checking tasks
 */

`default_nettype none
`timescale 1ns/1ps

`include "cpu8_macros.svh"

module cpu_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_WORDS    = 64;
    // steps run per test after reset release
    localparam int STEPS_RESET  = 8;
    localparam int STEPS_LOAD   = 5;
    localparam int STEPS_ARITH  = 28;
    localparam int STEPS_SHIFT  = 18;
    localparam int STEPS_BRANCH = 12;
    localparam int STEPS_UNDEF  = 5;
    localparam int STEPS_ALL    = STEPS_RESET + STEPS_LOAD + STEPS_ARITH + STEPS_SHIFT
                                + STEPS_BRANCH + STEPS_UNDEF;
    // six tests with reset and slack each
    localparam int WATCHDOG_NS  = (6 * (RESET_CYCLES + 2) + STEPS_ALL) * CLK_PERIOD + 500;

    logic                clk;
    logic                arst_n;
    cpu8_pkg::instr_t    instr;
    cpu8_pkg::addr_t     pc;
    logic                wb_en;
    cpu8_pkg::reg_idx_t  wb_reg;
    cpu8_pkg::data_t     wb_data;

    // word indexed instruction memory
    cpu8_pkg::instr_t    imem [MEM_WORDS];
    int                  load_idx;

    // reference model state
    cpu8_pkg::data_t     m_regs [`CPU8_REG_CNT];
    cpu8_pkg::addr_t     m_pc;

    integer              seed;
    int                  errors;
    int                  test_errors;
    int                  tests_run;
    int                  tests_failed;

    cpu i_cpu (
        .clk     (clk),
        .arst_n  (arst_n),
        .instr   (instr),
        .pc      (pc),
        .wb_en   (wb_en),
        .wb_reg  (wb_reg),
        .wb_data (wb_data)
    );

    // fetch answers in the same cycle
    assign instr = imem[pc[7:2]];

    always #(CLK_PERIOD / 2) clk = ~clk;

    // register-register format
    function automatic cpu8_pkg::instr_t enc_rr(input cpu8_pkg::opcode_t op,
            input cpu8_pkg::reg_idx_t rd, input cpu8_pkg::reg_idx_t rs1,
            input cpu8_pkg::reg_idx_t rs2);
        return {op, 5'b0, rd, 5'b0, rs1, 5'b0, rs2};
    endfunction

    // immediate format for loadi and shifts
    function automatic cpu8_pkg::instr_t enc_imm(input cpu8_pkg::opcode_t op,
            input cpu8_pkg::reg_idx_t rd, input cpu8_pkg::reg_idx_t rs1,
            input cpu8_pkg::data_t imm);
        return {op, 5'b0, rd, 5'b0, rs1, imm};
    endfunction

    // jump and branch with signed word offset in 23..16
    function automatic cpu8_pkg::instr_t enc_br(input cpu8_pkg::opcode_t op,
            input logic [7:0] off, input cpu8_pkg::reg_idx_t rs1,
            input cpu8_pkg::reg_idx_t rs2);
        return {op, off, 5'b0, rs1, 5'b0, rs2};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // unused words decode as an undefined opcode tagged with their index
    task automatic clear_program;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {8'hff, 24'(i)};
        end
        load_idx = 0;
    endtask

    task automatic put(input cpu8_pkg::instr_t w);
        imem[load_idx] = w;
        load_idx++;
    endtask

    // holds reset for the reset cycles and releases it 1 ns after an edge
    task automatic restart;
        arst_n = 1'b0;
        m_pc = '0;
        for (int i = 0; i < `CPU8_REG_CNT; i++) begin
            m_regs[i] = '0;
        end
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_value("pc in reset", pc, 32'd0);
            check_value("wb_en in reset", 32'(wb_en), 32'd0);
            @(posedge clk);
        end
        #1;
        arst_n = 1'b1;
    endtask

    // compare the trace of one retiring instruction mid-cycle and advance the model
    task automatic step_and_check;
        cpu8_pkg::instr_t   w;
        cpu8_pkg::opcode_t  op;
        cpu8_pkg::reg_idx_t rd;
        cpu8_pkg::data_t    a;
        cpu8_pkg::data_t    b;
        cpu8_pkg::data_t    imm;
        cpu8_pkg::data_t    res;
        logic               we;
        logic               taken;
        int                 off_words;
        w         = imem[m_pc[7:2]];
        op        = w[31:24];
        rd        = w[18:16];
        a         = m_regs[w[10:8]];
        b         = m_regs[w[2:0]];
        imm       = w[7:0];
        off_words = $signed(w[23:16]);
        we        = 1'b0;
        taken     = 1'b0;
        res       = '0;
        case (op)
            `CPU8_OP_LOADI: begin
                we  = 1'b1;
                res = imm;
            end
            `CPU8_OP_MOV: begin
                we  = 1'b1;
                res = b;
            end
            `CPU8_OP_ADD: begin
                we  = 1'b1;
                res = a + b;
            end
            `CPU8_OP_SUB: begin
                we  = 1'b1;
                res = a - b;
            end
            `CPU8_OP_AND: begin
                we  = 1'b1;
                res = a & b;
            end
            `CPU8_OP_OR: begin
                we  = 1'b1;
                res = a | b;
            end
            `CPU8_OP_SRL: begin
                we  = 1'b1;
                res = a >> imm[2:0];
            end
            `CPU8_OP_SLL: begin
                we  = 1'b1;
                res = a << imm[2:0];
            end
            `CPU8_OP_J:     taken = 1'b1;
            `CPU8_OP_BEQ:   taken = (a == b);
            `CPU8_OP_BNE:   taken = (a != b);
            default:        ;
        endcase
        check_value("pc", pc, m_pc);
        check_value("wb_en", 32'(wb_en), 32'(we));
        if (we) begin
            check_value("wb_reg", 32'(wb_reg), 32'(rd));
            check_value("wb_data", 32'(wb_data), 32'(res));
            m_regs[rd] = res;
        end
        // target relative to the following word
        m_pc = m_pc + 32'd4 + (taken ? 32'(off_words * 4) : 32'd0);
    endtask

    task automatic run_steps(input int n);
        for (int s = 0; s < n; s++) begin
            @(negedge clk);
            step_and_check();
            @(posedge clk);
        end
    endtask

    // program and reset change 1 ns after the edge that ended the last test
    task automatic begin_test;
        #1;
        test_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_errors);
        end
    endtask

    task automatic test_reset;
        begin_test();
        clear_program();
        restart();
        // only undefined words so pc walks by 4
        for (int k = 0; k < STEPS_RESET; k++) begin
            @(negedge clk);
            check_value("pc after release", pc, 32'(k * 4));
            step_and_check();
            @(posedge clk);
        end
        end_test("reset");
    endtask

    task automatic test_load_mov;
        begin_test();
        clear_program();
        put(enc_imm(`CPU8_OP_LOADI, 3'd1, 3'd0, 8'h5a));
        put(enc_imm(`CPU8_OP_LOADI, 3'd7, 3'd0, 8'hc3));
        // mov copies the second source
        put(enc_rr(`CPU8_OP_MOV, 3'd2, 3'd0, 3'd1));
        put(enc_rr(`CPU8_OP_MOV, 3'd0, 3'd0, 3'd7));
        put(enc_rr(`CPU8_OP_MOV, 3'd3, 3'd0, 3'd2));
        restart();
        run_steps(STEPS_LOAD);
        end_test("load_mov");
    endtask

    task automatic test_arith;
        cpu8_pkg::data_t v1;
        cpu8_pkg::data_t v2;
        begin_test();
        clear_program();
        for (int r = 0; r < 4; r++) begin
            v1 = $random(seed);
            v2 = $random(seed);
            put(enc_imm(`CPU8_OP_LOADI, 3'd1, 3'd0, v1));
            put(enc_imm(`CPU8_OP_LOADI, 3'd2, 3'd0, v2));
            put(enc_rr(`CPU8_OP_ADD, 3'd3, 3'd1, 3'd2));
            put(enc_rr(`CPU8_OP_SUB, 3'd4, 3'd1, 3'd2));
            put(enc_rr(`CPU8_OP_AND, 3'd5, 3'd1, 3'd2));
            put(enc_rr(`CPU8_OP_OR, 3'd6, 3'd1, 3'd2));
            put(enc_rr(`CPU8_OP_SUB, 3'd7, 3'd2, 3'd1));
        end
        restart();
        run_steps(STEPS_ARITH);
        end_test("arith_logic");
    endtask

    task automatic test_shift;
        cpu8_pkg::data_t v;
        logic [2:0]      sh;
        begin_test();
        clear_program();
        for (int r = 0; r < 6; r++) begin
            v = $random(seed);
            put(enc_imm(`CPU8_OP_LOADI, 3'd1, 3'd0, v));
            sh = $random(seed);
            put(enc_imm(`CPU8_OP_SRL, 3'd2, 3'd1, {5'b0, sh}));
            sh = $random(seed);
            put(enc_imm(`CPU8_OP_SLL, 3'd3, 3'd1, {5'b0, sh}));
        end
        restart();
        run_steps(STEPS_SHIFT);
        end_test("shift");
    endtask

    task automatic test_branch;
        begin_test();
        clear_program();
        put(enc_imm(`CPU8_OP_LOADI, 3'd1, 3'd0, 8'd5));
        put(enc_imm(`CPU8_OP_LOADI, 3'd2, 3'd0, 8'd5));
        put(enc_imm(`CPU8_OP_LOADI, 3'd3, 3'd0, 8'd9));
        // equal and taken over word 4
        put(enc_br(`CPU8_OP_BEQ, 8'd1, 3'd1, 3'd2));
        put(enc_imm(`CPU8_OP_LOADI, 3'd4, 3'd0, 8'hee));
        // equal so bne falls through
        put(enc_br(`CPU8_OP_BNE, 8'd1, 3'd1, 3'd2));
        put(enc_br(`CPU8_OP_BNE, 8'd2, 3'd1, 3'd3));
        put(enc_imm(`CPU8_OP_LOADI, 3'd5, 3'd0, 8'h11));
        put(enc_imm(`CPU8_OP_LOADI, 3'd5, 3'd0, 8'h22));
        put(enc_br(`CPU8_OP_BEQ, 8'd3, 3'd1, 3'd3));
        put(enc_br(`CPU8_OP_J, 8'd3, 3'd0, 3'd0));
        put(enc_imm(`CPU8_OP_LOADI, 3'd6, 3'd0, 8'h01));
        put(enc_br(`CPU8_OP_J, 8'd4, 3'd0, 3'd0));
        put(enc_imm(`CPU8_OP_LOADI, 3'd6, 3'd0, 8'h03));
        // backward jump to word 12
        put(enc_br(`CPU8_OP_J, 8'hfd, 3'd0, 3'd0));
        put(enc_imm(`CPU8_OP_LOADI, 3'd6, 3'd0, 8'h44));
        put(enc_imm(`CPU8_OP_LOADI, 3'd6, 3'd0, 8'h44));
        put(enc_imm(`CPU8_OP_LOADI, 3'd7, 3'd0, 8'h77));
        restart();
        run_steps(STEPS_BRANCH);
        end_test("control_flow");
    endtask

    task automatic test_undefined;
        begin_test();
        clear_program();
        put(enc_imm(`CPU8_OP_LOADI, 3'd1, 3'd0, 8'h3c));
        put({8'h0b, 5'b0, 3'd1, 16'h00ff});
        put({8'hff, 5'b0, 3'd1, 16'h0000});
        put({8'h80, 5'b0, 3'd1, 16'h0101});
        // r1 must still hold its loaded value
        put(enc_rr(`CPU8_OP_MOV, 3'd2, 3'd0, 3'd1));
        restart();
        run_steps(STEPS_UNDEF);
        end_test("undefined");
    endtask

    // watchdog sized from the step counts
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        // starts high so the first restart gives a real falling edge
        arst_n       = 1'b1;
        seed         = 32'h23fa;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        m_pc         = '0;
        clear_program();

        test_reset();
        test_load_mov();
        test_arith();
        test_shift();
        test_branch();
        test_undefined();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu8.f ====
+incdir+design
design/cpu8_pkg.sv
design/pc_unit.sv
design/control_unit.sv
design/reg_file.sv
design/alu.sv
design/cpu.sv
verif/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cpu8 testbench with Verilator, run it and scan the log.
# Exits non-zero unless the log holds the pass line.

LOG=sim.log

rm -f "$LOG" \
    && verilator --binary --timing --assert -Wno-fatal \
        -f cpu8.f \
        --top-module cpu_tb \
        -o cpu_tb \
    && ./obj_dir/cpu_tb | tee "$LOG" \
    && grep -q "ALL TESTS PASSED" "$LOG" \
    && echo "simulation passed, see $LOG" \
    || { echo "simulation failed, see $LOG"; exit 1; }
